/* project.f */
src/mips_isa_pkg.sv
src/profiler_pkg.sv
src/instr_decoder.sv
src/instr_classifier.sv
src/fetch_fsm.sv
src/fetch_counter.sv
src/class_tally.sv
src/instr_profiler_top.sv
test/tb_instr_profiler.sv
+incdir+include

/* Makefile */
# Verilator build and run for the instruction profiler testbench.

VERILATOR ?= verilator
TOP       ?= tb_instr_profiler
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* include/tb_ref_model.svh */
// Reference model for the profiler testbench.
// Encodes instruction words per symbol and predicts format and function class.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Nonzero rs, rt, rd and shamt keep SLL apart from NOP.
function automatic instr_word_t r_word(logic [5:0] fn);
    return {OP_SPECIAL, 5'd2, 5'd3, 5'd4, 5'd1, fn};
endfunction

function automatic instr_word_t s2_word(logic [5:0] fn);
    return {OP_SPECIAL2, 5'd2, 5'd3, 5'd4, 5'd0, fn};
endfunction

function automatic instr_word_t i_word(logic [5:0] op);
    return {op, 5'd2, 5'd3, 16'h0010};
endfunction

function automatic instr_word_t regimm_word(logic [4:0] rt);
    return {OP_REGIMM, 5'd2, rt, 16'h0008};
endfunction

function automatic instr_word_t sym_word(instr_sym_t s);
    instr_word_t w;
    case (s)
        NOP:     w = 32'h0;
        ADD:     w = r_word(FN_ADD);
        SUB:     w = r_word(FN_SUB);
        ADDU:    w = r_word(FN_ADDU);
        SUBU:    w = r_word(FN_SUBU);
        AND:     w = r_word(FN_AND);
        OR:      w = r_word(FN_OR);
        XOR:     w = r_word(FN_XOR);
        NOR:     w = r_word(FN_NOR);
        SLT:     w = r_word(FN_SLT);
        SLTU:    w = r_word(FN_SLTU);
        SLL:     w = r_word(FN_SLL);
        SLLV:    w = r_word(FN_SLLV);
        SRL:     w = r_word(FN_SRL);
        SRLV:    w = r_word(FN_SRLV);
        SRA:     w = r_word(FN_SRA);
        SRAV:    w = r_word(FN_SRAV);
        CLO:     w = s2_word(FN_CLO);
        CLZ:     w = s2_word(FN_CLZ);
        ADDI:    w = i_word(OP_ADDI);
        ADDIU:   w = i_word(OP_ADDIU);
        ANDI:    w = i_word(OP_ANDI);
        ORI:     w = i_word(OP_ORI);
        XORI:    w = i_word(OP_XORI);
        LUI:     w = i_word(OP_LUI);
        SLTI:    w = i_word(OP_SLTI);
        SLTIU:   w = i_word(OP_SLTIU);
        LW:      w = i_word(OP_LW);
        LH:      w = i_word(OP_LH);
        LHU:     w = i_word(OP_LHU);
        LB:      w = i_word(OP_LB);
        LBU:     w = i_word(OP_LBU);
        SW:      w = i_word(OP_SW);
        SH:      w = i_word(OP_SH);
        SB:      w = i_word(OP_SB);
        BEQ:     w = i_word(OP_BEQ);
        BNE:     w = i_word(OP_BNE);
        BLEZ:    w = i_word(OP_BLEZ);
        BGTZ:    w = i_word(OP_BGTZ);
        BGEZ:    w = regimm_word(RT_BGEZ);
        BLTZ:    w = regimm_word(RT_BLTZ);
        BGEZAL:  w = regimm_word(RT_BGEZAL);
        BLTZAL:  w = regimm_word(RT_BLTZAL);
        J:       w = {OP_J, 26'h0000400};
        JAL:     w = {OP_JAL, 26'h0000400};
        JR:      w = r_word(FN_JR);
        JALR:    w = r_word(FN_JALR);
        MULT:    w = r_word(FN_MULT);
        MULTU:   w = r_word(FN_MULTU);
        DIV:     w = r_word(FN_DIV);
        DIVU:    w = r_word(FN_DIVU);
        MADD:    w = s2_word(FN_MADD);
        MADDU:   w = s2_word(FN_MADDU);
        MSUB:    w = s2_word(FN_MSUB);
        MSUBU:   w = s2_word(FN_MSUBU);
        MFHI:    w = r_word(FN_MFHI);
        MFLO:    w = r_word(FN_MFLO);
        MTHI:    w = r_word(FN_MTHI);
        MTLO:    w = r_word(FN_MTLO);
        default: w = 32'hfc00_0000; // Opcode 0x3f is unused.
    endcase
    return w;
endfunction

function automatic instr_format_t model_format(instr_sym_t s);
    if (s inside {J, JAL}) begin
        return FORMAT_J;
    end
    if (s inside {ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
                  LW, LH, LHU, LB, LBU, SW, SH, SB,
                  BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL}) begin
        return FORMAT_I;
    end
    return FORMAT_R;
endfunction

function automatic instr_func_t model_func(instr_sym_t s);
    instr_func_t f;
    f = FUNC_OTHER;
    if (s inside {NOP, ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
                  SLL, SLLV, SRL, SRLV, SRA, SRAV, CLO, CLZ}) begin
        f = FUNC_CALC_R;
    end else if (s inside {ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU}) begin
        f = FUNC_CALC_I;
    end else if (s inside {LW, LH, LHU, LB, LBU}) begin
        f = FUNC_MEM_READ;
    end else if (s inside {SW, SH, SB}) begin
        f = FUNC_MEM_WRITE;
    end else if (s inside {BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL}) begin
        f = FUNC_BRANCH;
    end else if (s inside {J, JAL, JR, JALR}) begin
        f = FUNC_JUMP;
    end else if (s inside {MULT, MULTU, DIV, DIVU, MADD, MADDU, MSUB, MSUBU,
                           MFHI, MFLO, MTHI, MTLO}) begin
        f = FUNC_MULTDIV;
    end
    return f;
endfunction

// Empties the expected results and the model tallies for a new run.
task automatic begin_program();
    exp_syms.delete();
    for (int i = 0; i < 8; i++) begin
        exp_tally[i] = 0;
    end
endtask

// Places one word in memory and records what it should classify as.
task automatic load_word(wb_addr_t b, int idx, instr_word_t w, instr_sym_t s);
    mem[b + 32'(idx) * 32'd4] = w;
    exp_syms.push_back(s);
    exp_tally[model_func(s)]++;
endtask

`endif

/* test/tb_instr_profiler.sv */
// Testbench for the instruction profiler.
// Wishbone slave memory with random ack delay and directed tests.
`timescale 1ns/1ps
`default_nettype none

module tb_instr_profiler;
    import mips_isa_pkg::*;
    import profiler_pkg::*;

    localparam int TALLY_W = 16;
    localparam int TIMEOUT = 2000;

    logic                clk;
    logic                rst_n;
    logic                start;
    wb_addr_t            base;
    word_count_t         len;
    logic                busy;
    logic                done;
    wb_req_t             wb_req;
    wb_rsp_t             wb_rsp;
    class_result_t       result;
    instr_func_t         tally_sel;
    logic [TALLY_W-1:0]  tally_count;

    instr_word_t mem [wb_addr_t];
    instr_sym_t  exp_syms [$];
    int          exp_tally [8];
    wb_addr_t    exp_base;
    wb_addr_t    held_adr;
    int          xfer_idx;
    int          reads;
    int          delay;
    int          errors;
    int          err_mark;
    int          tests;
    logic        in_xfer;
    integer      seed = 5322;

    `include "tb_ref_model.svh"

    initial clk = 1'b0;
    always #2 clk = ~clk;

    instr_profiler_top #(
        .TALLY_W(TALLY_W)
    ) dut_i (
        .clk(clk), .rst_n(rst_n), .start(start), .base(base), .len(len),
        .busy(busy), .done(done), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .result(result), .tally_sel(tally_sel), .tally_count(tally_count)
    );

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic fail_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $finish;
    endtask

    // Unprogrammed locations.
    function automatic instr_word_t fill_word(wb_addr_t a);
        return a ^ 32'ha5c3_3c5a;
    endfunction

    // Slave memory, acks after a random number of wait cycles.
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_rsp  = '0;
            in_xfer = 1'b0;
        end else begin
            wb_rsp.ack = 1'b0;
            if (wb_req.cyc && wb_req.stb) begin
                if (!in_xfer) begin
                    in_xfer  = 1'b1;
                    held_adr = wb_req.adr;
                    delay    = int'($unsigned($random(seed)) % 5);
                    check("wb_req.adr", wb_req.adr, exp_base + 32'(xfer_idx) * 32'd4);
                    check("wb_req.we", 32'(wb_req.we), 32'd0);
                    check("wb_req.sel", 32'(wb_req.sel), 32'hf);
                end else begin
                    check("wb_req.adr held", wb_req.adr, held_adr);
                end
                if (delay == 0) begin
                    wb_rsp.ack = 1'b1;
                    wb_rsp.dat = mem.exists(wb_req.adr) ? mem[wb_req.adr]
                                                        : fill_word(wb_req.adr);
                    in_xfer = 1'b0;
                    xfer_idx++;
                    reads++;
                end else begin
                    delay--;
                end
            end else if (in_xfer) begin
                check("wb_req.cyc held", 32'(wb_req.cyc && wb_req.stb), 32'd1);
                in_xfer = 1'b0;
            end
        end
    end

    // Result monitor against the program order.
    always @(negedge clk) begin : result_monitor
        instr_sym_t s;
        if (rst_n && result.valid) begin
            if (exp_syms.size() == 0) begin
                $display("ERROR t=%0t result.valid got 1 expected 0", $time);
                errors++;
            end else begin
                s = exp_syms.pop_front();
                check("result.sym", 32'(result.sym), 32'(s));
                check("result.format", 32'(result.format), 32'(model_format(s)));
                check("result.func", 32'(result.func), 32'(model_func(s)));
            end
        end
    end

    // Starts a run and waits for done; poke gives a second start while busy.
    task automatic run_program(wb_addr_t b, int n, bit poke);
        int cycles;
        int reads0;
        exp_base = b;
        xfer_idx = 0;
        reads0   = reads;
        @(negedge clk);
        start = 1'b1;
        base  = b;
        len   = word_count_t'(n);
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (!done) begin
            check("busy", 32'(busy), 32'd1);
            @(negedge clk);
            cycles++;
            if (poke && cycles == 3) begin
                start = 1'b1;
                base  = 32'h9000_0000;
                len   = word_count_t'(3);
            end else begin
                start = 1'b0;
            end
            if (cycles > TIMEOUT) begin
                fail_timeout("done");
            end
        end
        if (n == 0) begin
            check("done latency", 32'(cycles), 32'd0); // Empty run ends one cycle on.
        end
        check("busy at done", 32'(busy), 32'd0);
        check("bus reads", 32'(reads - reads0), 32'(n));
        check("results left", 32'(exp_syms.size()), 32'd0);
        @(negedge clk);
        check("done pulse", 32'(done), 32'd0);
    endtask

    task automatic check_tallies();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            tally_sel = instr_func_t'(i);
            #1;
            check($sformatf("tally_count[%0d]", i), 32'(tally_count), 32'(exp_tally[i]));
        end
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic test_reset();
        check("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
        check("wb_req.stb", 32'(wb_req.stb), 32'd0);
        check("busy", 32'(busy), 32'd0);
        check("done", 32'(done), 32'd0);
        check("result.valid", 32'(result.valid), 32'd0);
        check_tallies();
        finish_test("reset");
    endtask

    task automatic test_classify();
        int n;
        begin_program();
        n = 0;
        for (int i = 0; i <= int'(UNKNOWN); i++) begin
            load_word(32'h1000, n, sym_word(instr_sym_t'(i)), instr_sym_t'(i));
            n++;
        end
        load_word(32'h1000, n, 32'h0000_0001, UNKNOWN); // SPECIAL, unused funct.
        n++;
        load_word(32'h1000, n, {OP_REGIMM, 5'd1, 5'h05, 16'h0}, UNKNOWN);
        n++;
        load_word(32'h1000, n, {OP_SPECIAL2, 20'h0, 6'h3f}, UNKNOWN);
        n++;
        run_program(32'h1000, n, 1'b0);
        check_tallies();
        finish_test("classify");
    endtask

    task automatic test_tally();
        instr_sym_t s;
        begin_program();
        for (int i = 0; i < 48; i++) begin
            s = instr_sym_t'($unsigned($random(seed)) % (int'(UNKNOWN) + 1));
            load_word(32'h4000_0100, i, sym_word(s), s);
        end
        run_program(32'h4000_0100, 48, 1'b0);
        check_tallies();
        finish_test("tally");
    endtask

    task automatic test_start_rules();
        begin_program();
        for (int i = 0; i < 8; i++) begin
            load_word(32'h3000, i, sym_word(instr_sym_t'(i * 7)), instr_sym_t'(i * 7));
        end
        run_program(32'h3000, 8, 1'b1); // Second start must be ignored.
        check_tallies();
        begin_program();
        run_program(32'h5000, 0, 1'b0); // Clears the tallies, no bus cycle.
        check_tallies();
        finish_test("start_rules");
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        base      = '0;
        len       = '0;
        tally_sel = FUNC_CALC_R;
        wb_rsp    = '0;
        in_xfer   = 1'b0;
        exp_base  = '0;
        held_adr  = '0;
        xfer_idx  = 0;
        reads     = 0;
        delay     = 0;
        errors    = 0;
        err_mark  = 0;
        tests     = 0;
        begin_program();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_classify();
        test_tally();
        test_start_rules();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/instr_profiler_top.sv */
// Instruction profiler top.
// Fetches words over Wishbone, decodes, classifies and tallies them.
`timescale 1ns/1ps
`default_nettype none

module instr_profiler_top #(
    parameter int TALLY_W = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  profiler_pkg::wb_addr_t      base,
    input  profiler_pkg::word_count_t   len,
    output logic                        busy,
    output logic                        done,
    output profiler_pkg::wb_req_t       wb_req,
    input  profiler_pkg::wb_rsp_t       wb_rsp,
    output profiler_pkg::class_result_t result,
    input  mips_isa_pkg::instr_func_t   tally_sel,
    output logic [TALLY_W-1:0]          tally_count
);
    import mips_isa_pkg::*;
    import profiler_pkg::*;

    logic          cyc;
    logic          stb;
    logic          load;
    logic          step;
    logic          last;
    logic          word_take;
    logic          dec_valid;
    wb_addr_t      adr;
    instr_sym_t    sym;
    instr_format_t format;
    instr_func_t   func;

    // Read-only single transfers.
    assign wb_req = '{cyc: cyc, stb: stb, we: 1'b0, adr: adr, sel: 4'hf, dat: '0};
    assign result = '{valid: dec_valid, sym: sym, format: format, func: func};

    fetch_fsm fsm_i (
        .clk(clk), .rst_n(rst_n), .start(start), .len(len), .last(last),
        .ack(wb_rsp.ack), .cyc(cyc), .stb(stb), .load(load), .step(step),
        .word_take(word_take), .busy(busy), .done(done)
    );

    fetch_counter cnt_i (
        .clk(clk), .rst_n(rst_n), .load(load), .step(step),
        .base(base), .len(len), .adr(adr), .last(last)
    );

    instr_decoder dec_i (
        .clk(clk), .rst_n(rst_n), .word_take(word_take), .word(wb_rsp.dat),
        .sym(sym), .valid(dec_valid)
    );

    instr_classifier cls_i (
        .sym(sym), .format(format), .func(func)
    );

    class_tally #(
        .TALLY_W(TALLY_W)
    ) tally_i (
        .clk(clk), .rst_n(rst_n), .clear(load), .inc(dec_valid), .func(func),
        .sel(tally_sel), .count(tally_count)
    );

endmodule

`default_nettype wire

/* src/class_tally.sv */
// Function class tally.
// Eight saturating counters, one per class, with a select read port.
`timescale 1ns/1ps
`default_nettype none

module class_tally #(
    parameter int TALLY_W = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear,
    input  logic                      inc,
    input  mips_isa_pkg::instr_func_t func,
    input  mips_isa_pkg::instr_func_t sel,
    output logic [TALLY_W-1:0]        count
);

    logic [TALLY_W-1:0] cnt [8];

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            for (int i = 0; i < 8; i++) begin
                cnt[i] <= '0;
            end
        end else if (inc && (cnt[func] != '1)) begin
            cnt[func] <= cnt[func] + 1'b1; // Holds at max.
        end
    end

    assign count = cnt[sel];

endmodule

`default_nettype wire

/* src/fetch_counter.sv */
// Fetch address and word counter.
`timescale 1ns/1ps
`default_nettype none

module fetch_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  logic                      step,
    input  profiler_pkg::wb_addr_t    base,
    input  profiler_pkg::word_count_t len,
    output profiler_pkg::wb_addr_t    adr,
    output logic                      last
);
    import profiler_pkg::*;

    word_count_t remaining;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adr       <= '0;
            remaining <= '0;
        end else if (load) begin
            adr       <= base;
            remaining <= len;
        end else if (step) begin
            adr       <= adr + wb_addr_t'(4); // Next word.
            remaining <= remaining - word_count_t'(1);
        end
    end

    assign last = (remaining == word_count_t'(1));

endmodule

`default_nettype wire

/* src/fetch_fsm.sv */
// Fetch sequencer.
// Runs start, one Wishbone read per word, decode drain and the done pulse.
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  profiler_pkg::word_count_t len,
    input  logic                      last,
    input  logic                      ack,
    output logic                      cyc,
    output logic                      stb,
    output logic                      load,
    output logic                      step,
    output logic                      word_take,
    output logic                      busy,
    output logic                      done
);

    typedef enum logic [2:0] {IDLE, REQ, GAP, DRAIN, FINISH} state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        load       = 1'b0;
        case (state)
            IDLE, FINISH: begin
                if (start) begin
                    load       = 1'b1;
                    state_next = (len == '0) ? FINISH : REQ; // Empty run ends at once.
                end else begin
                    state_next = IDLE;
                end
            end
            REQ: begin
                if (ack) begin
                    state_next = last ? DRAIN : GAP;
                end
            end
            GAP:     state_next = REQ; // One idle cycle between reads.
            DRAIN:   state_next = FINISH;
            default: state_next = IDLE;
        endcase
    end

    assign cyc       = (state == REQ);
    assign stb       = (state == REQ);
    assign word_take = cyc && stb && ack;
    assign step      = word_take;
    assign busy      = state inside {REQ, GAP, DRAIN};
    assign done      = (state == FINISH);

endmodule

`default_nettype wire

/* src/instr_classifier.sv */
// Instruction classifier.
// Sorts a symbol into its format and function class.
`timescale 1ns/1ps
`default_nettype none

module instr_classifier (
    input  mips_isa_pkg::instr_sym_t    sym,
    output mips_isa_pkg::instr_format_t format,
    output mips_isa_pkg::instr_func_t   func
);
    import mips_isa_pkg::*;

    logic is_i;
    logic is_j;
    logic calc_r;
    logic calc_i;
    logic mem_r;
    logic mem_w;
    logic br;
    logic jmp;
    logic md;

    assign calc_r = sym inside {NOP, ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
                                SLL, SLLV, SRL, SRLV, SRA, SRAV, CLO, CLZ};
    assign calc_i = sym inside {ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU};
    assign mem_r  = sym inside {LW, LH, LHU, LB, LBU};
    assign mem_w  = sym inside {SW, SH, SB};
    assign br     = sym inside {BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL};
    assign jmp    = sym inside {J, JAL, JR, JALR};
    assign md     = sym inside {MULT, MULTU, DIV, DIVU, MADD, MADDU, MSUB, MSUBU,
                                MFHI, MFLO, MTHI, MTLO};

    assign is_i = calc_i || mem_r || mem_w || br;
    assign is_j = sym inside {J, JAL};

    always_comb begin
        if (is_i) begin
            format = FORMAT_I;
        end else if (is_j) begin
            format = FORMAT_J;
        end else begin
            format = FORMAT_R; // Unknown lands here too.
        end
    end

    always_comb begin
        if (calc_r) begin
            func = FUNC_CALC_R;
        end else if (calc_i) begin
            func = FUNC_CALC_I;
        end else if (mem_r) begin
            func = FUNC_MEM_READ;
        end else if (mem_w) begin
            func = FUNC_MEM_WRITE;
        end else if (br) begin
            func = FUNC_BRANCH;
        end else if (jmp) begin
            func = FUNC_JUMP;
        end else if (md) begin
            func = FUNC_MULTDIV;
        end else begin
            func = FUNC_OTHER;
        end
    end

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
// Instruction decoder.
// Turns a fetched word into an instruction symbol, registered on word_take.
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     word_take,
    input  mips_isa_pkg::instr_word_t word,
    output mips_isa_pkg::instr_sym_t  sym,
    output logic                     valid
);
    import mips_isa_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;
    instr_sym_t sym_next;

    assign opcode = word[31:26];
    assign rt     = word[20:16];
    assign funct  = word[5:0];

    always_comb begin
        sym_next = UNKNOWN;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:   sym_next = (word == '0) ? NOP : SLL; // All zeros is NOP.
                    FN_SRL:   sym_next = SRL;
                    FN_SRA:   sym_next = SRA;
                    FN_SLLV:  sym_next = SLLV;
                    FN_SRLV:  sym_next = SRLV;
                    FN_SRAV:  sym_next = SRAV;
                    FN_JR:    sym_next = JR;
                    FN_JALR:  sym_next = JALR;
                    FN_MFHI:  sym_next = MFHI;
                    FN_MTHI:  sym_next = MTHI;
                    FN_MFLO:  sym_next = MFLO;
                    FN_MTLO:  sym_next = MTLO;
                    FN_MULT:  sym_next = MULT;
                    FN_MULTU: sym_next = MULTU;
                    FN_DIV:   sym_next = DIV;
                    FN_DIVU:  sym_next = DIVU;
                    FN_ADD:   sym_next = ADD;
                    FN_ADDU:  sym_next = ADDU;
                    FN_SUB:   sym_next = SUB;
                    FN_SUBU:  sym_next = SUBU;
                    FN_AND:   sym_next = AND;
                    FN_OR:    sym_next = OR;
                    FN_XOR:   sym_next = XOR;
                    FN_NOR:   sym_next = NOR;
                    FN_SLT:   sym_next = SLT;
                    FN_SLTU:  sym_next = SLTU;
                    default:  sym_next = UNKNOWN;
                endcase
            end
            OP_SPECIAL2: begin
                case (funct)
                    FN_MADD:  sym_next = MADD;
                    FN_MADDU: sym_next = MADDU;
                    FN_MSUB:  sym_next = MSUB;
                    FN_MSUBU: sym_next = MSUBU;
                    FN_CLZ:   sym_next = CLZ;
                    FN_CLO:   sym_next = CLO;
                    default:  sym_next = UNKNOWN;
                endcase
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ:   sym_next = BLTZ;
                    RT_BGEZ:   sym_next = BGEZ;
                    RT_BLTZAL: sym_next = BLTZAL;
                    RT_BGEZAL: sym_next = BGEZAL;
                    default:   sym_next = UNKNOWN;
                endcase
            end
            OP_J:     sym_next = J;
            OP_JAL:   sym_next = JAL;
            OP_BEQ:   sym_next = BEQ;
            OP_BNE:   sym_next = BNE;
            OP_BLEZ:  sym_next = BLEZ;
            OP_BGTZ:  sym_next = BGTZ;
            OP_ADDI:  sym_next = ADDI;
            OP_ADDIU: sym_next = ADDIU;
            OP_SLTI:  sym_next = SLTI;
            OP_SLTIU: sym_next = SLTIU;
            OP_ANDI:  sym_next = ANDI;
            OP_ORI:   sym_next = ORI;
            OP_XORI:  sym_next = XORI;
            OP_LUI:   sym_next = LUI;
            OP_LB:    sym_next = LB;
            OP_LH:    sym_next = LH;
            OP_LW:    sym_next = LW;
            OP_LBU:   sym_next = LBU;
            OP_LHU:   sym_next = LHU;
            OP_SB:    sym_next = SB;
            OP_SH:    sym_next = SH;
            OP_SW:    sym_next = SW;
            default:  sym_next = UNKNOWN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= word_take; // One cycle per fetched word.
        end
        if (word_take) begin
            sym <= sym_next;
        end
    end

endmodule

`default_nettype wire

/* src/profiler_pkg.sv */
// Profiler bus and result types.
// Wishbone request and response, address and count widths, classified result.
`default_nettype none

package profiler_pkg;

    localparam int LEN_W = 16;

    typedef logic [31:0] wb_addr_t;
    typedef logic [LEN_W-1:0] word_count_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // One classified instruction, 12 bits.
    typedef struct packed {
        logic                        valid;
        mips_isa_pkg::instr_sym_t    sym;
        mips_isa_pkg::instr_format_t format;
        mips_isa_pkg::instr_func_t   func;
    } class_result_t;

endpackage

`default_nettype wire

/* src/mips_isa_pkg.sv */
// MIPS ISA definitions shared by the decoder, the classifier and the model.
// Instruction symbols, field encodings, formats and function classes.
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] instr_word_t;

    typedef enum logic [5:0] {
        NOP,
        ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV, CLO, CLZ,
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        LW, LH, LHU, LB, LBU, SW, SH, SB,
        BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL,
        J, JAL, JR, JALR,
        MULT, MULTU, DIV, DIVU, MADD, MADDU, MSUB, MSUBU,
        MFHI, MFLO, MTHI, MTLO,
        UNKNOWN
    } instr_sym_t;

    typedef enum logic [1:0] {
        FORMAT_R,
        FORMAT_I,
        FORMAT_J
    } instr_format_t;

    // Also the tally index.
    typedef enum logic [2:0] {
        FUNC_CALC_R,
        FUNC_CALC_I,
        FUNC_MEM_READ,
        FUNC_MEM_WRITE,
        FUNC_BRANCH,
        FUNC_JUMP,
        FUNC_MULTDIV,
        FUNC_OTHER
    } instr_func_t;

    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_REGIMM   = 6'h01;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;

    // Primary opcodes.
    localparam logic [5:0] OP_J = 6'h02, OP_JAL = 6'h03, OP_BEQ = 6'h04, OP_BNE = 6'h05,
        OP_BLEZ = 6'h06, OP_BGTZ = 6'h07, OP_ADDI = 6'h08, OP_ADDIU = 6'h09,
        OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c, OP_ORI = 6'h0d,
        OP_XORI = 6'h0e, OP_LUI = 6'h0f, OP_LB = 6'h20, OP_LH = 6'h21,
        OP_LW = 6'h23, OP_LBU = 6'h24, OP_LHU = 6'h25, OP_SB = 6'h28,
        OP_SH = 6'h29, OP_SW = 6'h2b;

    // SPECIAL funct codes.
    localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR = 6'h08, FN_JALR = 6'h09,
        FN_MFHI = 6'h10, FN_MTHI = 6'h11, FN_MFLO = 6'h12, FN_MTLO = 6'h13,
        FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV = 6'h1a, FN_DIVU = 6'h1b,
        FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
        FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_NOR = 6'h27,
        FN_SLT = 6'h2a, FN_SLTU = 6'h2b;

    // SPECIAL2 funct codes.
    localparam logic [5:0] FN_MADD = 6'h00, FN_MADDU = 6'h01, FN_MSUB = 6'h04,
        FN_MSUBU = 6'h05, FN_CLZ = 6'h20, FN_CLO = 6'h21;

    // REGIMM rt codes.
    localparam logic [4:0] RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10,
        RT_BGEZAL = 5'h11;

endpackage

`default_nettype wire
